//--- project.f
design/gemm_cfg_pkg.sv
design/gemm_mem_pkg.sv
design/gemm_read_fsm.sv
design/gemm_workload_counter.sv
design/gemm_feeder_steer.sv
design/gemm_write_out.sv
design/gemm_ctl.sv
testbench/tb_clock_gen.sv
testbench/tb_gemm_ctl.sv

//--- Makefile
# Verilator build for the GEMM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_gemm_ctl
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_STR  ?= *** TEST PASSED ***

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_STR)'

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_gemm_ctl.sv
/*
 * GEMM controller testbench.
 * Random runs against a reference model of read order, feeder split,
 * write-back order and completion.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_gemm_ctl
  import gemm_cfg_pkg::*;
  import gemm_mem_pkg::*;
;

  localparam int NUM_RUNS    = 6;
  localparam int MAX_LINES   = (4 + 4) * 3 * 2 * 2;        // Largest read count per run
  localparam int MAX_GRID    = 30;
  localparam int RUN_CYCLES  = MAX_LINES * 8 + MAX_GRID * 8 + 60;
  localparam int WATCHDOG_NS = NUM_RUNS * RUN_CYCLES * 100;
  localparam int SETTLE_NS   = 25;                         // Quarter period past the drive
  localparam int RDY_LIMIT   = GRID_FIFO_DEPTH - GRID_FIFO_MARGIN;
  localparam int DRAIN_DEPTH = 2;                          // Pop to write strobe

  logic clk, i_rst_n, i_go, i_a_full, i_b_full, i_wr_alm_full, i_wr_rsp;
  gemm_cfg_t i_cfg;
  rd_rsp_t   i_rd_rsp;
  feed_t     i_grid, o_a_feed, o_b_feed;
  rd_req_t   o_rd;
  wr_req_t   o_wr;
  logic      o_grid_rdy, o_test_cmp;

  logic [31:0] rng_state = 32'hff49;

  addr_t exp_addr[$];       // Model read order
  logic  exp_sel[$];        // 1 when the block is B
  line_t pend_rsp[$];       // Read data not yet returned
  line_t feed_data_q[$];    // Expected feeder lines
  logic  feed_sel_q[$];
  line_t wr_data_q[$];      // Expected write data

  tb_clock_gen u_clk (.o_clk(clk));

  gemm_ctl i_dut (
    .clk(clk), .i_rst_n(i_rst_n), .i_go(i_go), .i_cfg(i_cfg), .i_rd_rsp(i_rd_rsp),
    .i_a_full(i_a_full), .i_b_full(i_b_full), .i_grid(i_grid),
    .i_wr_alm_full(i_wr_alm_full), .i_wr_rsp(i_wr_rsp), .o_rd(o_rd),
    .o_a_feed(o_a_feed), .o_b_feed(o_b_feed), .o_wr(o_wr),
    .o_grid_rdy(o_grid_rdy), .o_test_cmp(o_test_cmp)
  );

  // ------------------------------------------------------------
  // Random source and failure exit
  // ------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + int'(lcg_next() % 32'(hi - lo + 1));
  endfunction

  // True about once in den calls, from the upper bits
  function automatic logic rand_hit(int den);
    logic [31:0] v;
    v = lcg_next();
    return (int'(v[31:16]) % den) == 0;
  endfunction

  function automatic line_t rand_line();
    line_t v;
    for (int i = 0; i < CL_W / 32; i++) v[i*32 +: 32] = lcg_next();
    return v;
  endfunction

  task automatic fail_stop();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_feed(input feed_t got, input feed_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s valid %b data differs %b", $time, what,
               got.valid, got.data !== exp.data);
      fail_stop();
    end
  endtask

  task automatic check_wr(input wr_req_t got, input wr_req_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s addr %h expected %h data differs %b", $time, what,
               got.addr, exp.addr, got.data !== exp.data);
      fail_stop();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
      fail_stop();
    end
  endtask

  // Model of the read walk with pb outermost, then pa, then workspace
  task automatic build_reads(input gemm_cfg_t c);
    int base;
    for (int pb = 0; pb < int'(c.num_part_b); pb++)
      for (int pa = 0; pa < int'(c.num_part_a); pa++)
        for (int w = 0; w < 2 * int'(c.num_block); w++) begin
          if (w % 2 == 0)
            base = int'(A_BASE) + (pa * int'(c.num_block) + w / 2) * int'(c.rows_block);
          else
            base = int'(B_BASE) + (pb * int'(c.num_block) + w / 2) * int'(c.cols_block);
          for (int l = 0; l < int'((w % 2 == 0) ? c.rows_block : c.cols_block); l++) begin
            exp_addr.push_back(addr_t'(base + l));
            exp_sel.push_back(w % 2 == 1);
          end
        end
  endtask

  // ------------------------------------------------------------
  // One run from reset to the quiet tail
  // ------------------------------------------------------------
  task automatic run_one();
    int      n_grid, grid_sent, rsp_idx, rsp_pend, rsp_sent, prev_sent, split, wr_idx;
    logic    sel, cmp_seen;
    feed_t   exp_f;
    wr_req_t exp_w;
    i_rst_n = 1'b0;  // Reset and idle inputs
    i_go = 1'b0;
    i_a_full = 1'b0;
    i_b_full = 1'b0;
    i_wr_alm_full = 1'b0;
    i_wr_rsp = 1'b0;
    i_rd_rsp = '0;
    i_grid = '0;
    n_grid = rand_range(4, MAX_GRID);
    i_cfg = '{num_block: cnt_t'(rand_range(1, 3)), num_part_a: cnt_t'(rand_range(1, 2)),
              num_part_b: cnt_t'(rand_range(1, 2)), rows_block: cnt_t'(rand_range(1, 4)),
              cols_block: cnt_t'(rand_range(1, 4)), test_complete: cnt_t'(n_grid)};
    repeat (2) @(negedge clk);
    check_bit(o_grid_rdy, 1'b0, "o_grid_rdy in reset");
    i_rst_n = 1'b1;
    @(negedge clk);
    check_bit(o_rd.valid, 1'b0, "o_rd.valid after reset");
    check_bit(o_a_feed.valid, 1'b0, "o_a_feed.valid after reset");
    check_bit(o_b_feed.valid, 1'b0, "o_b_feed.valid after reset");
    check_bit(o_wr.valid, 1'b0, "o_wr.valid after reset");
    check_bit(o_test_cmp, 1'b0, "o_test_cmp after reset");
    check_bit(o_grid_rdy, 1'b1, "o_grid_rdy one cycle after reset");
    build_reads(i_cfg);
    split = int'(i_cfg.rows_block) + int'(i_cfg.cols_block);
    grid_sent = 0;
    rsp_idx = 0;
    rsp_pend = 0;
    rsp_sent = 0;
    prev_sent = 0;
    cmp_seen = 1'b0;
    i_go = 1'b1;
    forever begin
      @(negedge clk);
      if (o_a_feed.valid || o_b_feed.valid) begin
        if (feed_data_q.size() == 0) begin
          $display("Feeder strobe without a read response");
          fail_stop();
        end
        exp_f = '{valid: 1'b1, data: feed_data_q.pop_front()};
        if (feed_sel_q.pop_front()) begin
          check_feed(o_b_feed, exp_f, "o_b_feed");
          check_bit(o_a_feed.valid, 1'b0, "o_a_feed.valid");
        end else begin
          check_feed(o_a_feed, exp_f, "o_a_feed");
          check_bit(o_b_feed.valid, 1'b0, "o_b_feed.valid");
        end
      end
      if (o_wr.valid) begin
        if (wr_data_q.size() == 0) begin
          $display("Write issued without a grid word");
          fail_stop();
        end
        wr_idx = grid_sent - wr_data_q.size();
        exp_w = '{valid: 1'b1, addr: WR_BASE + addr_t'(wr_idx), data: wr_data_q.pop_front()};
        check_wr(o_wr, exp_w, "o_wr");
        rsp_pend++;
      end
      // Occupancy lies between the unwritten words less the drain and the unwritten words
      if (wr_data_q.size() < RDY_LIMIT)
        check_bit(o_grid_rdy, 1'b1, "o_grid_rdy with room");
      else if (wr_data_q.size() >= RDY_LIMIT + DRAIN_DEPTH)
        check_bit(o_grid_rdy, 1'b0, "o_grid_rdy near full");
      check_bit(o_test_cmp, prev_sent >= n_grid, "o_test_cmp");  // One cycle behind count
      cmp_seen  = o_test_cmp;
      prev_sent = rsp_sent;
      if (exp_addr.size() == 0 && pend_rsp.size() == 0 && feed_data_q.size() == 0 &&
          grid_sent == n_grid && wr_data_q.size() == 0 && rsp_pend == 0 && cmp_seen)
        break;
      // Drive next cycle
      i_a_full      = rand_hit(4);
      i_b_full      = rand_hit(4);
      i_wr_alm_full = rand_hit(4);
      i_rd_rsp = '0;
      if (pend_rsp.size() != 0 && rand_hit(2)) begin
        i_rd_rsp = '{valid: 1'b1, data: pend_rsp.pop_front()};
        feed_data_q.push_back(i_rd_rsp.data);
        feed_sel_q.push_back((rsp_idx % split) >= int'(i_cfg.rows_block));
        rsp_idx++;
      end
      i_grid = '0;
      if (grid_sent < n_grid && o_grid_rdy && rand_hit(2)) begin
        i_grid = '{valid: 1'b1, data: rand_line()};
        wr_data_q.push_back(i_grid.data);
        grid_sent++;
      end
      i_wr_rsp = 1'b0;
      if (rsp_pend > 0 && rand_hit(2)) begin
        i_wr_rsp = 1'b1;
        rsp_pend--;
        rsp_sent++;
      end
      // Read strobe follows the flags just driven
      #(SETTLE_NS);
      if (o_rd.valid) begin
        if (exp_addr.size() == 0) begin
          $display("Read request issued after the last expected line");
          fail_stop();
        end
        sel = exp_sel.pop_front();
        check_bit(sel ? i_b_full : i_a_full, 1'b0, "full flag of read target");
        check_addr(o_rd.addr, exp_addr.pop_front(), "o_rd.addr");
        pend_rsp.push_back(rand_line());
      end
    end
    i_rd_rsp = '0;  // Quiet tail where nothing more may come out
    i_grid   = '0;
    i_wr_rsp = 1'b0;
    repeat (6) begin
      @(negedge clk);
      check_bit(o_rd.valid, 1'b0, "o_rd.valid after run");
      check_bit(o_wr.valid, 1'b0, "o_wr.valid after run");
      check_bit(o_test_cmp, 1'b1, "o_test_cmp sticky");
    end
    i_go = 1'b0;
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the run did not finish in time");
    fail_stop();
  end

  initial begin
    for (int r = 0; r < NUM_RUNS; r++) run_one();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : tb_gemm_ctl

`default_nettype wire

//--- testbench/tb_clock_gen.sv
/*
 * Testbench clock source, 100 ns period.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic o_clk
);

  initial o_clk = 1'b0;
  always #50 o_clk = ~o_clk;  // Half period

endmodule : tb_clock_gen

`default_nettype wire

//--- design/gemm_ctl.sv
/*
 * GEMM accelerator controller top.
 * Ties the read FSM, workload counter, feeder steering and write-back.
 */

`timescale 1ns/1ps
`default_nettype none

module gemm_ctl
  import gemm_cfg_pkg::*;
  import gemm_mem_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      i_rst_n,
  input  wire logic      i_go,
  input  wire gemm_cfg_t i_cfg,
  input  wire rd_rsp_t   i_rd_rsp,
  input  wire logic      i_a_full,
  input  wire logic      i_b_full,
  input  wire feed_t     i_grid,
  input  wire logic      i_wr_alm_full,
  input  wire logic      i_wr_rsp,
  output rd_req_t        o_rd,
  output feed_t          o_a_feed,
  output feed_t          o_b_feed,
  output wr_req_t        o_wr,
  output logic           o_grid_rdy,
  output logic           o_test_cmp
);

  // Counter to FSM
  addr_t base;
  logic  sel_b;
  logic  all_done;
  logic  advance;   // FSM back to counter

  gemm_read_fsm u_read_fsm (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_go      (i_go),
    .i_cfg     (i_cfg),
    .i_a_full  (i_a_full),
    .i_b_full  (i_b_full),
    .i_base    (base),
    .i_sel_b   (sel_b),
    .i_all_done(all_done),
    .o_advance (advance),
    .o_rd      (o_rd)
  );

  gemm_workload_counter u_workload_counter (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_cfg     (i_cfg),
    .i_advance (advance),
    .o_base    (base),
    .o_sel_b   (sel_b),
    .o_all_done(all_done)
  );

  gemm_feeder_steer u_feeder_steer (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_go    (i_go),
    .i_cfg   (i_cfg),
    .i_rd_rsp(i_rd_rsp),
    .o_a_feed(o_a_feed),
    .o_b_feed(o_b_feed)
  );

  gemm_write_out u_write_out (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_go         (i_go),
    .i_cfg        (i_cfg),
    .i_grid       (i_grid),
    .i_wr_alm_full(i_wr_alm_full),
    .i_wr_rsp     (i_wr_rsp),
    .o_grid_rdy   (o_grid_rdy),
    .o_wr         (o_wr),
    .o_test_cmp   (o_test_cmp)
  );

endmodule : gemm_ctl

`default_nettype wire

//--- design/gemm_write_out.sv
/*
 * Grid result write-back.
 * Buffers grid lines in a FIFO, drains them as writes at rising
 * addresses and flags completion from the write responses.
 */

`timescale 1ns/1ps
`default_nettype none

module gemm_write_out
  import gemm_cfg_pkg::*;
  import gemm_mem_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      i_rst_n,
  input  wire logic      i_go,
  input  wire gemm_cfg_t i_cfg,
  input  wire feed_t     i_grid,
  input  wire logic      i_wr_alm_full,
  input  wire logic      i_wr_rsp,
  output logic           o_grid_rdy,
  output wr_req_t        o_wr,
  output logic           o_test_cmp
);

  localparam int RDY_LIMIT = GRID_FIFO_DEPTH - GRID_FIFO_MARGIN;

  line_t                 fifo_mem [GRID_FIFO_DEPTH];
  logic [GRID_PTR_W-1:0] wr_ptr;
  logic [GRID_PTR_W-1:0] rd_ptr;
  logic [GRID_PTR_W:0]   occ, occ_nxt;   // Entries held
  logic                  push;
  logic                  pop;
  logic                  rd_vld_q;       // Drain stage 1 valid
  line_t                 rd_data_q;
  addr_t                 seq;            // Write sequence index
  cnt_t                  rsp_cnt;

  // ----------------------------------------------------------
  // Result FIFO
  // ----------------------------------------------------------
  assign push    = i_grid.valid && (occ != GRID_FIFO_DEPTH);  // Grid honors rdy
  assign pop     = (occ != '0) && !i_wr_alm_full;
  assign occ_nxt = occ + (GRID_PTR_W+1)'(push) - (GRID_PTR_W+1)'(pop);

  always_ff @(posedge clk) begin
    if (push) fifo_mem[wr_ptr] <= i_grid.data;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      occ        <= '0;
      o_grid_rdy <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      occ        <= occ_nxt;
      o_grid_rdy <= (occ_nxt < RDY_LIMIT);  // Tracks occupancy of the coming cycle
    end
  end

  // ----------------------------------------------------------
  // Drain, two stages from pop to write strobe
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      rd_vld_q      <= 1'b0;
      o_wr.valid    <= 1'b0;
      seq           <= '0;
    end else begin
      rd_vld_q   <= pop;
      o_wr.valid <= rd_vld_q;
      if (rd_vld_q) seq <= seq + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) rd_data_q <= fifo_mem[rd_ptr];
    o_wr.addr <= WR_BASE + seq;
    o_wr.data <= rd_data_q;
  end

  // ----------------------------------------------------------
  // Completion
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      rsp_cnt    <= '0;
      o_test_cmp <= 1'b0;
    end else begin
      if (i_wr_rsp) rsp_cnt <= rsp_cnt + 1'b1;
      if (i_go && (rsp_cnt == i_cfg.test_complete)) o_test_cmp <= 1'b1;  // Sticky
    end
  end

endmodule : gemm_write_out

`default_nettype wire

//--- design/gemm_feeder_steer.sv
/*
 * Feeder steering.
 * Sends rows_block response lines to the A feeder, then
 * cols_block lines to the B feeder, and repeats.
 */

`timescale 1ns/1ps
`default_nettype none

module gemm_feeder_steer
  import gemm_cfg_pkg::*;
  import gemm_mem_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      i_rst_n,
  input  wire logic      i_go,
  input  wire gemm_cfg_t i_cfg,
  input  wire rd_rsp_t   i_rd_rsp,
  output feed_t          o_a_feed,
  output feed_t          o_b_feed
);

  typedef enum logic {FILL_A, FILL_B} phase_t;

  phase_t phase;
  cnt_t   el_cnt;      // Lines steered in this phase
  cnt_t   phase_len;
  logic   a_vld;
  logic   b_vld;
  line_t  feed_data;   // Shared, valid picks the feeder

  assign phase_len = (phase == FILL_B) ? i_cfg.cols_block : i_cfg.rows_block;

  assign o_a_feed = '{valid: a_vld, data: feed_data};
  assign o_b_feed = '{valid: b_vld, data: feed_data};

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      phase  <= FILL_A;
      el_cnt <= '0;
      a_vld  <= 1'b0;
      b_vld  <= 1'b0;
    end else begin
      a_vld <= i_rd_rsp.valid && (phase == FILL_A);
      b_vld <= i_rd_rsp.valid && (phase == FILL_B);
      if (!i_go) begin                   // Realign between runs
        phase  <= FILL_A;
        el_cnt <= '0;
      end else if (i_rd_rsp.valid) begin
        if (el_cnt == phase_len - 1'b1) begin
          el_cnt <= '0;
          phase  <= (phase == FILL_A) ? FILL_B : FILL_A;
        end else begin
          el_cnt <= el_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rd_rsp.valid) feed_data <= i_rd_rsp.data;
  end

endmodule : gemm_feeder_steer

`default_nettype wire

//--- design/gemm_workload_counter.sv
/*
 * Workload and workspace counter.
 * Walks the A/B blocks of every part pair and registers the
 * base address of the block that comes next.
 */

`timescale 1ns/1ps
`default_nettype none

module gemm_workload_counter
  import gemm_cfg_pkg::*;
  import gemm_mem_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      i_rst_n,
  input  wire gemm_cfg_t i_cfg,
  input  wire logic      i_advance,   // Current block fully issued
  output addr_t          o_base,
  output logic           o_sel_b,
  output logic           o_all_done
);

  logic [CNT_W:0] ws, nxt_ws;       // Workspace index, up to 2*num_block
  logic [CNT_W:0] ws_max;
  cnt_t           pa, nxt_pa;       // A part
  cnt_t           pb, nxt_pb;       // B part
  addr_t          a_off;
  addr_t          b_off;

  assign ws_max = {i_cfg.num_block, 1'b0} - 1'b1;

  // ----------------------------------------------------------
  // Index update by the address rule
  // ----------------------------------------------------------
  always_comb begin
    nxt_ws = ws;
    nxt_pa = pa;
    nxt_pb = pb;
    if (i_advance) begin
      if (ws == ws_max) begin
        nxt_ws = '0;
        if (pa == i_cfg.num_part_a - 1'b1) begin
          nxt_pa = '0;
          nxt_pb = (pb == i_cfg.num_part_b - 1'b1) ? '0 : pb + 1'b1;  // Wrap for next run
        end else begin
          nxt_pa = pa + 1'b1;
        end
      end else begin
        nxt_ws = ws + 1'b1;
      end
    end
  end

  // Block offsets of the index set that takes effect
  assign a_off = (ADDR_W'(nxt_pa) * ADDR_W'(i_cfg.num_block) + ADDR_W'(nxt_ws[CNT_W:1]))
                 * ADDR_W'(i_cfg.rows_block);
  assign b_off = (ADDR_W'(nxt_pb) * ADDR_W'(i_cfg.num_block) + ADDR_W'(nxt_ws[CNT_W:1]))
                 * ADDR_W'(i_cfg.cols_block);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      ws         <= '0;
      pa         <= '0;
      pb         <= '0;
      o_sel_b    <= 1'b0;
      o_all_done <= 1'b0;
    end else begin
      ws         <= nxt_ws;
      pa         <= nxt_pa;
      pb         <= nxt_pb;
      o_sel_b    <= nxt_ws[0];               // Odd workspace reads B
      o_all_done <= (nxt_ws == ws_max) && (nxt_pa == i_cfg.num_part_a - 1'b1)
                    && (nxt_pb == i_cfg.num_part_b - 1'b1);
    end
  end

  // Recomputed every cycle
  always_ff @(posedge clk) begin
    o_base <= nxt_ws[0] ? B_BASE + b_off : A_BASE + a_off;
  end

endmodule : gemm_workload_counter

`default_nettype wire

//--- design/gemm_read_fsm.sv
/*
 * Read request FSM.
 * Issues one cache line read per cycle for the current block and
 * pauses while the target feeder reports full.
 */

`timescale 1ns/1ps
`default_nettype none

module gemm_read_fsm
  import gemm_cfg_pkg::*;
  import gemm_mem_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      i_rst_n,
  input  wire logic      i_go,
  input  wire gemm_cfg_t i_cfg,
  input  wire logic      i_a_full,
  input  wire logic      i_b_full,
  input  wire addr_t     i_base,      // Block base from counter
  input  wire logic      i_sel_b,     // Current block is B
  input  wire logic      i_all_done,  // Current block is the last one
  output logic           o_advance,   // Block finished strobe
  output rd_req_t        o_rd
);

  typedef enum logic [1:0] {IDLE, CALC, SEND, DONE} state_t;

  state_t state;
  logic   go_q;       // Registered start level
  logic   sel_b_q;    // Target of the block in flight
  cnt_t   line_cnt;   // Lines issued in this block
  cnt_t   blk_len;    // Lines in this block
  addr_t  rd_addr;    // Next line address
  logic   tgt_full;
  logic   issue;
  logic   last_line;

  // ----------------------------------------------------------
  // Request strobe, combinational on the current full flag
  // ----------------------------------------------------------
  assign tgt_full  = sel_b_q ? i_b_full : i_a_full;
  assign issue     = (state == SEND) && !tgt_full;
  assign last_line = (line_cnt == blk_len - 1'b1);
  assign o_advance = issue && last_line;
  assign o_rd      = '{valid: issue, addr: rd_addr};

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state    <= IDLE;
      go_q     <= 1'b0;
      sel_b_q  <= 1'b0;
      line_cnt <= '0;
      blk_len  <= '0;
    end else begin
      go_q <= i_go;
      case (state)
        IDLE: if (go_q) state <= CALC;
        CALC: begin                       // Counter outputs settled here
          sel_b_q  <= i_sel_b;
          blk_len  <= i_sel_b ? i_cfg.cols_block : i_cfg.rows_block;
          line_cnt <= '0;
          state    <= SEND;
        end
        SEND: begin
          if (issue) begin
            line_cnt <= line_cnt + 1'b1;
            if (last_line) state <= i_all_done ? DONE : CALC;
          end
        end
        DONE: if (!go_q) state <= IDLE;   // Wait for the run to drop
        default: state <= IDLE;
      endcase
    end
  end

  // Line address, loaded at block start then stepped per strobe
  always_ff @(posedge clk) begin
    if (state == CALC) rd_addr <= i_base;
    else if (issue)    rd_addr <= rd_addr + 1'b1;
  end

endmodule : gemm_read_fsm

`default_nettype wire

//--- design/gemm_mem_pkg.sv
/*
 * GEMM controller memory side package.
 * Region bases, grid FIFO sizing and the request/response structs.
 */

`default_nettype none

package gemm_mem_pkg;
  import gemm_cfg_pkg::*;

  // Region bases in cache line units
  localparam addr_t A_BASE  = 20'h00000;
  localparam addr_t B_BASE  = 20'h40000;
  localparam addr_t WR_BASE = 20'h80000;

  // ----------------------------------------------------------
  // Grid result FIFO
  // ----------------------------------------------------------
  localparam int GRID_FIFO_DEPTH  = 16;
  localparam int GRID_FIFO_MARGIN = 4;   // Hold off grid at this much free space
  localparam int GRID_PTR_W       = $clog2(GRID_FIFO_DEPTH);

  // ----------------------------------------------------------
  // Bus structs, all single cycle strobes
  // ----------------------------------------------------------
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic  valid;
    line_t data;
  } rd_rsp_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    line_t data;
  } wr_req_t;

  typedef struct packed {
    logic  valid;
    line_t data;
  } feed_t;

endpackage : gemm_mem_pkg

`default_nettype wire

//--- design/gemm_cfg_pkg.sv
/*
 * GEMM controller configuration package.
 * Widths, basic data types and the run configuration struct.
 */

`default_nettype none

package gemm_cfg_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int ADDR_W = 20;   // Cache line address bits
  localparam int CL_W   = 512;  // One cache line
  localparam int CNT_W  = 16;   // Config counts

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [CL_W-1:0]   line_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  // ----------------------------------------------------------
  // Run configuration, held stable while go is high
  // ----------------------------------------------------------
  typedef struct packed {
    cnt_t num_block;      // Blocks per workload
    cnt_t num_part_a;     // A parts
    cnt_t num_part_b;     // B parts
    cnt_t rows_block;     // Lines per A block
    cnt_t cols_block;     // Lines per B block
    cnt_t test_complete;  // Expected write responses
  } gemm_cfg_t;

endpackage : gemm_cfg_pkg

`default_nettype wire
